/* status_unit.f */
hdl/status_flags_pkg.sv
hdl/micro_op_pkg.sv
hdl/alu_unit.sv
hdl/flag_control_decoder.sv
hdl/processor_status.sv
hdl/status_unit_top.sv
tb/status_unit_assertions.sv
tb/status_unit_tb.sv

/* Makefile */
TOP     = status_unit_tb
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f status_unit.f --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): status_unit.f hdl/*.sv tb/*.sv
	verilator --binary --timing --assert -f status_unit.f --top-module $(TOP) --Mdir $(OBJ_DIR)

# The log decides the result, the simulator exit status is not used
sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

/* tb/status_unit_input.txt */
// Columns in hex: uop a b result P (P is checked one clock later)
// uop 10 pulses reset and checks P only, uop FF ends the list
0 55 AA 55 00  // NOP
1 01 01 02 00
1 7F 01 80 C0  // Overflow into N
1 FF 01 00 03  // Carry out, zero
1 00 00 01 00  // Uses the carry from the line above
B 00 00 00 01  // SEC
1 7F 00 80 C0  // 7F+00+C overflows
2 50 30 1F 01  // SBC with borrow
2 50 30 20 01
2 50 B0 A0 C0
2 00 00 FF 80
B 00 00 00 81
2 42 42 00 03
A 00 00 00 02  // CLC
B 00 00 00 03
1 80 80 01 41  // Sets C and V
3 F0 0F 00 43  // AND keeps C and V
4 80 01 81 C1
5 FF FF 00 43
8 7E 00 7E 41  // LDA
8 00 00 00 43
6 81 00 02 41  // ASL
6 40 00 80 C0
7 01 00 00 43  // LSR
7 FE 00 7F 40
F 00 00 00 00  // CLV
D 00 00 00 04  // SEI
E 08 00 08 0C  // D from bit 3 of a
E F7 00 F7 04
B 00 00 00 05
0 FF FF FF 05  // NOP holds P
C 00 00 00 01  // CLI
A 00 00 00 00
9 FF 00 FF DF  // PLP, bit 5 stays clear
1 10 20 31 1C  // Loaded carry used
9 20 00 20 00
9 C3 00 C3 C3
10 00 00 00 00 // Reset clears the loaded flags
0 00 00 00 00
1 01 FF 00 03
FF 00 00 00 00

/* tb/status_unit_tb.sv */
// Flag subsystem testbench
// Replays the vector file through status_unit_top and checks result and P
`timescale 1ns/100ps
`default_nettype none

module status_unit_tb
    import micro_op_pkg::*, status_flags_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_VECTORS  = 64;
    localparam int FIELDS       = 5;          // uop, a, b, result, P
    localparam logic [7:0] RESET_MARK = 8'h10;
    localparam logic [7:0] END_MARK   = 8'hFF;

    logic       clk = 1'b0;
    logic       reset_n;
    uop_e       uop;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] result;
    logic [7:0] p;

    logic [7:0] vec_mem [0:MAX_VECTORS*FIELDS-1];
    int         vec_count = 0;
    int         cur_line  = 0;

    status_unit_top uut (
        .i_clk     (clk),
        .i_reset_n (reset_n),
        .i_uop     (uop),
        .i_a       (a),
        .i_b       (b),
        .o_result  (result),
        .o_p       (p)
    );

    bind processor_status status_unit_assertions u_assertions (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_ctrl    (i_ctrl),
        .i_alu     (i_alu),
        .i_p       (o_p)
    );

    initial
    begin
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Lines before the end marker
    function automatic int count_vectors();
        int n;
        n = 0;
        while (n < MAX_VECTORS && vec_mem[n*FIELDS] != END_MARK)
            n++;
        return n;
    endfunction

    task automatic report_mismatch(input string what, input logic [7:0] got,
                                   input logic [7:0] expected);
        $display("ERR %0t: line %0d, %s is %02h, expected %02h",
                 $time, cur_line, what, got, expected);
        $display("Verification failed");
        $fatal(1, "Mismatch on %s", what);
    endtask

    // Reset must win over a PLP that would set every flag
    task automatic hold_reset_with_load();
        reset_n = 1'b0;
        uop     = UOP_PLP;
        a       = 8'hFF;
        b       = 8'hFF;
        repeat (RESET_CYCLES) @(negedge clk);
    endtask

    task automatic release_reset();
        reset_n = 1'b1;
        uop     = UOP_NOP;
        a       = 8'h00;
        b       = 8'h00;
    endtask

    // Called on a falling edge, returns on the next one
    task automatic run_vector(input int line);
        logic [7:0] exp_result;
        logic [7:0] exp_p;
        exp_result = vec_mem[line*FIELDS+3];
        exp_p      = vec_mem[line*FIELDS+4];
        uop = uop_e'(vec_mem[line*FIELDS][3:0]);
        a   = vec_mem[line*FIELDS+1];
        b   = vec_mem[line*FIELDS+2];
        #(CLK_PERIOD/4);                      // Result settles before the rising edge
        assert (result === exp_result)
            else report_mismatch("o_result", result, exp_result);
        @(negedge clk);
        assert (p === exp_p)
            else report_mismatch("o_p", p, exp_p);
    endtask

    initial
    begin : stimulus
        logic [7:0] exp_p;
        reset_n = 1'b0;
        uop     = UOP_NOP;
        a       = 8'h00;
        b       = 8'h00;
        $readmemh("tb/status_unit_input.txt", vec_mem);
        vec_count = count_vectors();
        if (vec_count == 0)
        begin
            $display("The vector file holds no test lines");
            $display("Verification failed");
            $fatal(1, "Empty vector file");
        end

        hold_reset_with_load();
        assert (p === P_RESET)
            else report_mismatch("o_p after power-on reset", p, P_RESET);
        release_reset();

        for (int line = 0; line < vec_count; line++)
        begin
            cur_line = line + 1;
            if (vec_mem[line*FIELDS] == RESET_MARK)
            begin
                exp_p = vec_mem[line*FIELDS+4];
                hold_reset_with_load();
                assert (p === exp_p)
                    else report_mismatch("o_p after reset", p, exp_p);
                release_reset();
            end
            else
            begin
                run_vector(line);
            end
        end

        $display("Verification passed");
        $finish;
    end

    // Budget of one cycle per line plus room for the resets
    initial
    begin : watchdog
        wait (vec_count > 0);
        #((vec_count + 20) * CLK_PERIOD);
        $display("Timeout: the test did not finish in time, stuck near line %0d", cur_line);
        $display("Verification failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

/* tb/status_unit_assertions.sv */
// Status register checks
// Bound into processor_status to watch reset, idle hold and the C and V loads
`timescale 1ns/100ps
`default_nettype none

module status_unit_assertions
    import status_flags_pkg::*, micro_op_pkg::*;
(
    input wire logic        i_clk,
    input wire logic        i_reset_n,
    input wire flag_ctrl_t  i_ctrl,
    input wire alu_result_t i_alu,
    input wire logic [7:0]  i_p
);

    logic any_load;

    // Every strobe, ir5 itself is only a data value
    assign any_load = i_ctrl.db0_c | i_ctrl.ir5_c | i_ctrl.acr_c
                    | i_ctrl.db1_z | i_ctrl.dbz_z
                    | i_ctrl.db2_i | i_ctrl.ir5_i
                    | i_ctrl.db3_d | i_ctrl.ir5_d
                    | i_ctrl.db4_b
                    | i_ctrl.db6_v | i_ctrl.avr_v
                    | i_ctrl.db7_n;

    // C follows the ALU carry, which beats the ir5 and bus sources
    c_from_acr: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_ctrl.acr_c |=> i_p[FLAG_C] == $past(i_alu.acr))
        else $error("C does not match the ALU carry");

    reset_value: assert property (@(posedge i_clk) !i_reset_n |=> i_p == P_RESET)
        else $error("P is not at its reset value after reset");

    hold_when_idle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !any_load |=> $stable(i_p))
        else $error("P changed with no load strobe active");

    // V follows the ALU overflow sampled with the strobe
    v_from_avr: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_ctrl.avr_v |=> i_p[FLAG_V] == $past(i_alu.avr))
        else $error("V does not match the ALU overflow");

endmodule

`default_nettype wire

/* hdl/status_unit_top.sv */
// Flag subsystem top level
// Decoder and ALU side by side feeding the processor status register
`timescale 1ns/100ps
`default_nettype none

module status_unit_top
    import micro_op_pkg::*, status_flags_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_reset_n,
    input  wire uop_e       i_uop,
    input  wire logic [7:0] i_a,
    input  wire logic [7:0] i_b,
    output logic [7:0]      o_result,
    output logic [7:0]      o_p
);

    alu_op_e     alu_op;
    flag_ctrl_t  ctrl;
    alu_result_t alu_res;

    flag_control_decoder u_decoder (
        .i_uop    (i_uop),
        .o_alu_op (alu_op),
        .o_ctrl   (ctrl)
    );

    // Carry in is the flag as it stands before the edge
    alu_unit u_alu (
        .i_a     (i_a),
        .i_b     (i_b),
        .i_carry (o_p[FLAG_C]),
        .i_op    (alu_op),
        .o_res   (alu_res)
    );

    processor_status u_status (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_ctrl    (ctrl),
        .i_alu     (alu_res),
        .o_p       (o_p)
    );

    assign o_result = alu_res.result;

endmodule

`default_nettype wire

/* hdl/processor_status.sv */
// Processor status register (P)
// Holds C, Z, I, D, B, V and N with prioritised per-flag load sources
`timescale 1ns/100ps
`default_nettype none

module processor_status
    import status_flags_pkg::*, micro_op_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_reset_n,
    input  wire flag_ctrl_t  i_ctrl,
    input  wire alu_result_t i_alu,
    output logic [7:0]       o_p
);

    logic [7:0] db;
    logic       dbz;
    logic       c_q;
    logic       z_q;
    logic       i_q;
    logic       d_q;
    logic       b_q;
    logic       v_q;
    logic       n_q;

    assign db  = i_alu.result;        // Internal data bus
    assign dbz = ~(|db);

    // Carry
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            c_q <= P_RESET[FLAG_C];
        else if (i_ctrl.acr_c)
            c_q <= i_alu.acr;
        else if (i_ctrl.ir5_c)
            c_q <= i_ctrl.ir5;
        else if (i_ctrl.db0_c)
            c_q <= db[FLAG_C];
    end

    // Zero, computed result wins over a bus load
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            z_q <= P_RESET[FLAG_Z];
        else if (i_ctrl.dbz_z)
            z_q <= dbz;
        else if (i_ctrl.db1_z)
            z_q <= db[FLAG_Z];
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            i_q <= P_RESET[FLAG_I];
        else if (i_ctrl.ir5_i)
            i_q <= i_ctrl.ir5;
        else if (i_ctrl.db2_i)
            i_q <= db[FLAG_I];
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            d_q <= P_RESET[FLAG_D];
        else if (i_ctrl.ir5_d)
            d_q <= i_ctrl.ir5;
        else if (i_ctrl.db3_d)
            d_q <= db[FLAG_D];
    end

    // Break only ever comes from the bus
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            b_q <= P_RESET[FLAG_B];
        else if (i_ctrl.db4_b)
            b_q <= db[FLAG_B];
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            v_q <= P_RESET[FLAG_V];
        else if (i_ctrl.avr_v)
            v_q <= i_alu.avr;         // Overrides bus bit 6
        else if (i_ctrl.db6_v)
            v_q <= db[FLAG_V];
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            n_q <= P_RESET[FLAG_N];
        else if (i_ctrl.db7_n)
            n_q <= db[FLAG_N];
    end

    always_comb
    begin
        o_p         = '0;             // Bit 5 stays zero
        o_p[FLAG_C] = c_q;
        o_p[FLAG_Z] = z_q;
        o_p[FLAG_I] = i_q;
        o_p[FLAG_D] = d_q;
        o_p[FLAG_B] = b_q;
        o_p[FLAG_V] = v_q;
        o_p[FLAG_N] = n_q;
    end

endmodule

`default_nettype wire

/* hdl/flag_control_decoder.sv */
// Flag control decoder
// Maps a micro-operation to its ALU operation and status register load strobes
`timescale 1ns/100ps
`default_nettype none

module flag_control_decoder
    import micro_op_pkg::*, status_flags_pkg::*;
(
    input  wire uop_e   i_uop,
    output alu_op_e     o_alu_op,
    output flag_ctrl_t  o_ctrl
);

    always_comb
    begin
        o_alu_op = ALU_PASS;
        o_ctrl   = '0;                        // NOP leaves P alone
        case (i_uop)
            UOP_ADC, UOP_SBC:
            begin
                o_alu_op     = (i_uop == UOP_ADC) ? ALU_ADD : ALU_SUB;
                o_ctrl.acr_c = 1'b1;
                o_ctrl.avr_v = 1'b1;
                o_ctrl.dbz_z = 1'b1;
                o_ctrl.db7_n = 1'b1;
            end
            UOP_AND, UOP_ORA, UOP_EOR, UOP_LDA:
            begin
                case (i_uop)
                    UOP_AND: o_alu_op = ALU_AND;
                    UOP_ORA: o_alu_op = ALU_OR;
                    UOP_EOR: o_alu_op = ALU_XOR;
                    default: o_alu_op = ALU_PASS;   // LDA
                endcase
                o_ctrl.dbz_z = 1'b1;
                o_ctrl.db7_n = 1'b1;
            end
            UOP_ASL, UOP_LSR:
            begin
                o_alu_op     = (i_uop == UOP_ASL) ? ALU_SHL : ALU_SHR;
                o_ctrl.acr_c = 1'b1;
                o_ctrl.dbz_z = 1'b1;
                o_ctrl.db7_n = 1'b1;
            end
            UOP_PLP:
            begin
                // Bus carries operand a, every flag loads from it
                o_ctrl.db0_c = 1'b1;
                o_ctrl.db1_z = 1'b1;
                o_ctrl.db2_i = 1'b1;
                o_ctrl.db3_d = 1'b1;
                o_ctrl.db4_b = 1'b1;
                o_ctrl.db6_v = 1'b1;
                o_ctrl.db7_n = 1'b1;
            end
            UOP_CLC, UOP_SEC:
            begin
                o_ctrl.ir5   = (i_uop == UOP_SEC);
                o_ctrl.ir5_c = 1'b1;
            end
            UOP_CLI, UOP_SEI:
            begin
                o_ctrl.ir5   = (i_uop == UOP_SEI);
                o_ctrl.ir5_i = 1'b1;
            end
            UOP_CLD_SED:
            begin
                o_ctrl.db3_d = 1'b1;              // D from bus bit 3
            end
            UOP_CLV:
            begin
                o_ctrl.avr_v = 1'b1;              // ALU gives avr = 0 on PASS
            end
            default:
            begin
                o_alu_op = ALU_PASS;
                o_ctrl   = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/alu_unit.sv */
// 8-bit ALU
// Add, subtract, logic, shifts and pass-through, with carry and overflow out
`timescale 1ns/100ps
`default_nettype none

module alu_unit
    import micro_op_pkg::*;
(
    input  wire logic [7:0]  i_a,
    input  wire logic [7:0]  i_b,
    input  wire logic        i_carry,
    input  wire alu_op_e     i_op,
    output alu_result_t      o_res
);

    logic [7:0] addend;
    logic [8:0] sum;

    // SBC is a + ~b + c, same adder as ADC
    assign addend = (i_op == ALU_SUB) ? ~i_b : i_b;
    assign sum    = {1'b0, i_a} + {1'b0, addend} + {8'd0, i_carry};

    always_comb
    begin
        o_res = '0;
        case (i_op)
            ALU_ADD, ALU_SUB:
            begin
                o_res.result = sum[7:0];
                o_res.acr    = sum[8];
                // Same-sign inputs giving a result of the other sign
                o_res.avr    = (i_a[7] == addend[7]) && (sum[7] != i_a[7]);
            end
            ALU_AND:
            begin
                o_res.result = i_a & i_b;
            end
            ALU_OR:
            begin
                o_res.result = i_a | i_b;
            end
            ALU_XOR:
            begin
                o_res.result = i_a ^ i_b;
            end
            ALU_SHL:
            begin
                o_res.result = {i_a[6:0], 1'b0};
                o_res.acr    = i_a[7];        // Bit shifted out
            end
            ALU_SHR:
            begin
                o_res.result = {1'b0, i_a[7:1]};
                o_res.acr    = i_a[0];
            end
            ALU_PASS:
            begin
                o_res.result = i_a;           // Also clears V for CLV
            end
            default:
            begin
                o_res = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/micro_op_pkg.sv */
// Micro-operation definitions
// Operation codes seen by the decoder and ALU, and the ALU output bundle
`default_nettype none

package micro_op_pkg;

    // Encodings are fixed, the stimulus file uses them directly
    typedef enum logic [3:0] {
        UOP_NOP     = 4'h0,
        UOP_ADC     = 4'h1,
        UOP_SBC     = 4'h2,
        UOP_AND     = 4'h3,
        UOP_ORA     = 4'h4,
        UOP_EOR     = 4'h5,
        UOP_ASL     = 4'h6,
        UOP_LSR     = 4'h7,
        UOP_LDA     = 4'h8,
        UOP_PLP     = 4'h9,
        UOP_CLC     = 4'hA,
        UOP_SEC     = 4'hB,
        UOP_CLI     = 4'hC,
        UOP_SEI     = 4'hD,
        UOP_CLD_SED = 4'hE,   // New D taken from operand a bit 3
        UOP_CLV     = 4'hF
    } uop_e;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SHL  = 3'd5,
        ALU_SHR  = 3'd6,
        ALU_PASS = 3'd7
    } alu_op_e;

    // Result doubles as the data bus of the status register
    typedef struct packed {
        logic [7:0] result;
        logic       acr;      // Carry out
        logic       avr;      // Signed overflow
    } alu_result_t;

endpackage

`default_nettype wire

/* hdl/status_flags_pkg.sv */
// Status flag definitions
// Bit positions in P and the per-flag load strobes of the status register
`default_nettype none

package status_flags_pkg;

    // Flag positions in P, bit 5 is unused
    localparam int FLAG_C = 0;    // Carry
    localparam int FLAG_Z = 1;    // Zero
    localparam int FLAG_I = 2;    // Interrupt disable
    localparam int FLAG_D = 3;    // Decimal mode
    localparam int FLAG_B = 4;    // Break command
    localparam int FLAG_V = 6;    // Overflow
    localparam int FLAG_N = 7;    // Negative

    localparam logic [7:0] P_RESET = 8'h00;

    // Load strobes, grouped by the flag they write
    typedef struct packed {
        logic ir5;      // Value written by the ir5 loads
        logic db0_c;
        logic ir5_c;
        logic acr_c;
        logic db1_z;
        logic dbz_z;
        logic db2_i;
        logic ir5_i;
        logic db3_d;
        logic ir5_d;
        logic db4_b;
        logic db6_v;
        logic avr_v;
        logic db7_n;
    } flag_ctrl_t;

endpackage

`default_nettype wire
